/* verilog/wb_pkg.sv */
// Wishbone bus widths and data type
// Address word union and the slave address map
package wb_pkg;

   localparam int DW = 32;
   localparam int AW = 16;
   localparam int SW = 4;

   typedef logic [DW-1:0] wb_data_t;

   // Address fields, msb first
   typedef struct packed {
      logic [5:0] slave;
      logic [7:0] reg_index;
      logic [1:0] lane;
   } wb_addr_f_t;

   // Decoder looks at the slave field, slaves at reg_index
   typedef union packed {
      logic [AW-1:0] raw;
      wb_addr_f_t    f;
   } wb_addr_u;

   // Slave codes in the upper six address bits
   localparam logic [5:0] SLV_READBACK = 6'b110011;
   localparam logic [5:0] SLV_SETTINGS = 6'b110101;
   localparam logic [5:0] SLV_PIC      = 6'b110110;

   localparam int N_SLAVES = 3;

endpackage

/* verilog/ctrl_pkg.sv */
// Setting addresses, reset values and control widths
// Interrupt bit positions and the compatibility number
package ctrl_pkg;

   localparam int SET_AW = 8;

   ////////////////////////////////////////
   // Setting register addresses
   localparam logic [SET_AW-1:0] SR_CLOCK   = 8'd0;
   localparam logic [SET_AW-1:0] SR_SERDES  = 8'd1;
   localparam logic [SET_AW-1:0] SR_ADC     = 8'd2;
   localparam logic [SET_AW-1:0] SR_LED     = 8'd3;
   localparam logic [SET_AW-1:0] SR_PHY     = 8'd4;
   localparam logic [SET_AW-1:0] SR_LED_SRC = 8'd8;

   // Hardware drives LEDs 1 to 4 out of reset
   localparam logic [7:0] LED_SRC_RESET = 8'h1E;

   // Bump when the register map changes
   localparam logic [31:0] COMPAT_NUM = 32'd2;

   ////////////////////////////////////////
   // Interrupts
   localparam int IRQ_W          = 16;
   localparam int IRQ_PHY        = 4;
   localparam int IRQ_SERDES     = 12;
   localparam int IRQ_CLK_STATUS = 13;

   typedef logic [7:0]       led_word_t;
   typedef logic [IRQ_W-1:0] irq_vec_t;

endpackage

/* verilog/wb_if.sv */
// Wishbone slave-side bus with master and slave modports
interface wb_if;

   wb_pkg::wb_addr_u          adr;
   wb_pkg::wb_data_t          dat_w;
   wb_pkg::wb_data_t          dat_r;
   logic [wb_pkg::SW-1:0]     sel;
   logic                      we;
   logic                      stb;
   logic                      cyc;
   logic                      ack;

   // Decoder side
   modport master (output adr, dat_w, sel, we, stb, cyc,
                   input  dat_r, ack);

   // Peripheral side
   modport slave  (input  adr, dat_w, sel, we, stb, cyc,
                   output dat_r, ack);

endinterface

/* verilog/wb_slave_decode.sv */
// Single master address decoder and response mux
module wb_slave_decode (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic [wb_pkg::AW-1:0] adr_i,
   input  wb_pkg::wb_data_t      dat_i,
   input  logic [wb_pkg::SW-1:0] sel_i,
   input  logic                  we_i,
   input  logic                  stb_i,
   input  logic                  cyc_i,
   output wb_pkg::wb_data_t      dat_o,
   output logic                  ack_o,
   output logic                  err_o,
   wb_if.master                  rb_bus,
   wb_if.master                  set_bus,
   wb_if.master                  pic_bus
);

   wb_pkg::wb_addr_u            adr;
   logic [wb_pkg::N_SLAVES-1:0] hit;

   assign adr = adr_i;

   // Match bits: readback, settings, pic
   assign hit[0] = (adr.f.slave == wb_pkg::SLV_READBACK);
   assign hit[1] = (adr.f.slave == wb_pkg::SLV_SETTINGS);
   assign hit[2] = (adr.f.slave == wb_pkg::SLV_PIC);

   ////////////////////////////////////////
   // Request fan-out, only stb is steered
   assign rb_bus.adr    = adr;
   assign rb_bus.dat_w  = dat_i;
   assign rb_bus.sel    = sel_i;
   assign rb_bus.we     = we_i;
   assign rb_bus.cyc    = cyc_i;
   assign rb_bus.stb    = stb_i & hit[0];

   assign set_bus.adr   = adr;
   assign set_bus.dat_w = dat_i;
   assign set_bus.sel   = sel_i;
   assign set_bus.we    = we_i;
   assign set_bus.cyc   = cyc_i;
   assign set_bus.stb   = stb_i & hit[1];

   assign pic_bus.adr   = adr;
   assign pic_bus.dat_w = dat_i;
   assign pic_bus.sel   = sel_i;
   assign pic_bus.we    = we_i;
   assign pic_bus.cyc   = cyc_i;
   assign pic_bus.stb   = stb_i & hit[2];

   ////////////////////////////////////////
   // Response path
   always_comb begin
      case (1'b1)
         hit[0]:  dat_o = rb_bus.dat_r;
         hit[1]:  dat_o = set_bus.dat_r;
         hit[2]:  dat_o = pic_bus.dat_r;
         default: dat_o = '0;
      endcase
   end

   assign ack_o = rb_bus.ack | set_bus.ack | pic_bus.ack;

   // Nobody home at this slave code
   assign err_o = stb_i & cyc_i & ~(|hit);

   a_one_slave_stb: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({rb_bus.stb, set_bus.stb, pic_bus.stb}));

endmodule

/* verilog/settings_bus_slave.sv */
// Wishbone to settings bus bridge
module settings_bus_slave (
   input  logic                        wb_clk,
   input  logic                        wb_rst,
   wb_if.slave                         bus,
   output logic                        set_stb_o,
   output logic [ctrl_pkg::SET_AW-1:0] set_addr_o,
   output wb_pkg::wb_data_t            set_data_o
);

   logic req;

   // New request, not yet acked
   assign req = bus.stb & bus.cyc & ~bus.ack;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         bus.ack   <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         bus.ack   <= req;
         set_stb_o <= req & bus.we;
      end
   end

   // Address and data latch with the strobe
   always_ff @(posedge wb_clk) begin
      if (req && bus.we) begin
         set_addr_o <= bus.adr.f.reg_index;
         set_data_o <= bus.dat_w;
      end
   end

   // Write-only slave
   assign bus.dat_r = '0;

   a_stb_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_o |=> !set_stb_o);

endmodule

/* verilog/setting_bank.sv */
// Control setting registers for clock gen, SERDES, ADC and PHY
// LED register and hardware/software LED source mux
module setting_bank (
   input  logic                        wb_clk,
   input  logic                        wb_rst,
   input  logic                        set_stb_i,
   input  logic [ctrl_pkg::SET_AW-1:0] set_addr_i,
   input  wb_pkg::wb_data_t            set_data_i,
   input  logic                        run_rx_i,
   input  logic                        run_tx_i,
   input  logic                        clk_status_i,
   input  logic                        serdes_link_up_i,
   output ctrl_pkg::led_word_t         leds_o,
   output logic                        clock_ready_o,
   output logic [1:0]                  clk_en_o,
   output logic [1:0]                  clk_sel_o,
   output logic                        ser_enable_o,
   output logic                        ser_prbsen_o,
   output logic                        ser_loopen_o,
   output logic                        ser_rx_en_o,
   output logic                        adc_oe_a_o,
   output logic                        adc_on_a_o,
   output logic                        adc_oe_b_o,
   output logic                        adc_on_b_o,
   output logic                        phy_reset_n_o
);

   logic [4:0]          clock_r;
   logic [3:0]          serdes_r;
   logic [3:0]          adc_r;
   logic                phy_r;
   ctrl_pkg::led_word_t led_sw;
   ctrl_pkg::led_word_t led_src;
   ctrl_pkg::led_word_t led_hw;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_r  <= '0;
         serdes_r <= '0;
         adc_r    <= '0;
         phy_r    <= 1'b0;
         led_sw   <= '0;
         led_src  <= ctrl_pkg::LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            ctrl_pkg::SR_CLOCK:   clock_r  <= set_data_i[4:0];
            ctrl_pkg::SR_SERDES:  serdes_r <= set_data_i[3:0];
            ctrl_pkg::SR_ADC:     adc_r    <= set_data_i[3:0];
            ctrl_pkg::SR_PHY:     phy_r    <= set_data_i[0];
            ctrl_pkg::SR_LED:     led_sw   <= set_data_i[7:0];
            ctrl_pkg::SR_LED_SRC: led_src  <= set_data_i[7:0];
            default: ;
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_r;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_r;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_r;
   assign phy_reset_n_o = ~phy_r;

   ////////////////////////////////////////
   // LED mux, source bit 1 picks hardware
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* verilog/readback_mux.sv */
// Status word readback with free-running cycle counter
module readback_mux (
   input  logic               wb_clk,
   input  logic               wb_rst,
   wb_if.slave                bus,
   input  logic               sim_mode_i,
   input  logic [3:0]         clock_divider_i,
   input  ctrl_pkg::irq_vec_t irq_i
);

   wb_pkg::wb_data_t cycle_count;
   wb_pkg::wb_data_t word;
   logic             req;

   assign req = bus.stb & bus.cyc & ~bus.ack;

   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         cycle_count <= '0;
      else
         cycle_count <= cycle_count + 1'b1;
   end

   // Words not listed here read zero
   always_comb begin
      case (bus.adr.f.reg_index[3:0])
         4'd9:    word = {sim_mode_i, 27'd0, clock_divider_i};
         4'd12:   word = ctrl_pkg::COMPAT_NUM;
         4'd13:   word = wb_pkg::wb_data_t'(irq_i);
         4'd15:   word = cycle_count;
         default: word = '0;
      endcase
   end

   // Writes take the ack and nothing else
   always_ff @(posedge wb_clk) begin
      if (wb_rst)
         bus.ack <= 1'b0;
      else
         bus.ack <= req;
   end

   always_ff @(posedge wb_clk) begin
      if (req)
         bus.dat_r <= word;
   end

endmodule

/* verilog/pic.sv */
// Interrupt controller with edge/level, polarity, mask and pending registers
module pic (
   input  logic               wb_clk,
   input  logic               wb_rst,
   wb_if.slave                bus,
   input  ctrl_pkg::irq_vec_t irq_i,
   output logic               int_o
);

   ctrl_pkg::irq_vec_t edge_en;
   ctrl_pkg::irq_vec_t polarity;
   ctrl_pkg::irq_vec_t mask;
   ctrl_pkg::irq_vec_t pending;
   ctrl_pkg::irq_vec_t pending_n;
   ctrl_pkg::irq_vec_t active;
   ctrl_pkg::irq_vec_t active_q;
   ctrl_pkg::irq_vec_t wdata;
   ctrl_pkg::irq_vec_t wmask;
   logic               req;
   logic               wr;

   assign req   = bus.stb & bus.cyc & ~bus.ack;
   assign wr    = req & bus.we;
   assign wdata = bus.dat_w[ctrl_pkg::IRQ_W-1:0];
   // Byte lanes of the 16-bit registers
   assign wmask = {{8{bus.sel[1]}}, {8{bus.sel[0]}}};

   // Polarity 1 is active high
   assign active = ~(irq_i ^ polarity);

   ////////////////////////////////////////
   // Pending update, new events win over a clear
   always_comb begin
      pending_n = pending;
      if (wr && bus.adr.f.reg_index == 8'd3)
         pending_n = pending & ~(wdata & wmask);
      pending_n = pending_n | (edge_en & active & ~active_q) | (~edge_en & active);
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         edge_en  <= '0;
         polarity <= '0;
         mask     <= '1;
         pending  <= '0;
         active_q <= '0;
         bus.ack  <= 1'b0;
      end else begin
         bus.ack  <= req;
         active_q <= active;
         pending  <= pending_n;
         if (wr) begin
            case (bus.adr.f.reg_index)
               8'd0:    edge_en  <= (edge_en & ~wmask) | (wdata & wmask);
               8'd1:    polarity <= (polarity & ~wmask) | (wdata & wmask);
               8'd2:    mask     <= (mask & ~wmask) | (wdata & wmask);
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (req) begin
         case (bus.adr.f.reg_index)
            8'd0:    bus.dat_r <= wb_pkg::wb_data_t'(edge_en);
            8'd1:    bus.dat_r <= wb_pkg::wb_data_t'(polarity);
            8'd2:    bus.dat_r <= wb_pkg::wb_data_t'(mask);
            8'd3:    bus.dat_r <= wb_pkg::wb_data_t'(pending);
            default: bus.dat_r <= '0;
         endcase
      end
   end

   assign int_o = |(pending & ~mask);

   a_int_pending: assert property (@(posedge wb_clk) disable iff (wb_rst)
      int_o |-> (pending != '0));

endmodule

/* verilog/u2_ctrl_core.sv */
// Control plane top: address decoder, settings bus and setting bank
// Status readback and interrupt controller
module u2_ctrl_core (
   input  logic                  wb_clk,
   input  logic                  wb_rst,
   input  logic [wb_pkg::AW-1:0] adr_i,
   input  logic [wb_pkg::DW-1:0] dat_i,
   input  logic [wb_pkg::SW-1:0] sel_i,
   input  logic                  we_i,
   input  logic                  stb_i,
   input  logic                  cyc_i,
   output logic [wb_pkg::DW-1:0] dat_o,
   output logic                  ack_o,
   output logic                  err_o,
   output logic                  int_o,
   input  logic                  run_rx_i,
   input  logic                  run_tx_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   input  logic                  phy_int_n_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   output logic [7:0]            leds_o,
   output logic                  clock_ready_o,
   output logic [1:0]            clk_en_o,
   output logic [1:0]            clk_sel_o,
   output logic                  ser_enable_o,
   output logic                  ser_prbsen_o,
   output logic                  ser_loopen_o,
   output logic                  ser_rx_en_o,
   output logic                  adc_oe_a_o,
   output logic                  adc_on_a_o,
   output logic                  adc_oe_b_o,
   output logic                  adc_on_b_o,
   output logic                  phy_reset_n_o
);

   logic                        set_stb;
   logic [ctrl_pkg::SET_AW-1:0] set_addr;
   wb_pkg::wb_data_t            set_data;
   ctrl_pkg::irq_vec_t          irq;

   wb_if rb_bus ();
   wb_if set_bus ();
   wb_if pic_bus ();

   // Live interrupt sources only
   assign irq = (ctrl_pkg::irq_vec_t'(phy_int_n_i) << ctrl_pkg::IRQ_PHY)
              | (ctrl_pkg::irq_vec_t'(serdes_link_up_i) << ctrl_pkg::IRQ_SERDES)
              | (ctrl_pkg::irq_vec_t'(clk_status_i) << ctrl_pkg::IRQ_CLK_STATUS);

   ////////////////////////////////////////
   // Bus decode
   wb_slave_decode decode0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .adr_i(adr_i), .dat_i(dat_i), .sel_i(sel_i), .we_i(we_i),
      .stb_i(stb_i), .cyc_i(cyc_i),
      .dat_o(dat_o), .ack_o(ack_o), .err_o(err_o),
      .rb_bus(rb_bus.master), .set_bus(set_bus.master), .pic_bus(pic_bus.master));

   ////////////////////////////////////////
   // Settings bus, slave 7
   settings_bus_slave settings0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .bus(set_bus.slave),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   setting_bank bank0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .run_rx_i(run_rx_i), .run_tx_i(run_tx_i),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .leds_o(leds_o),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .phy_reset_n_o(phy_reset_n_o));

   ////////////////////////////////////////
   // Status readback, slave 5
   readback_mux readback0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .bus(rb_bus.slave),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i), .irq_i(irq));

   ////////////////////////////////////////
   // Interrupt controller, slave 8
   pic pic0 (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .bus(pic_bus.slave),
      .irq_i(irq), .int_o(int_o));

endmodule

/* verification/tb_u2_ctrl_core.sv */
// Testbench for the control core: clock, reset, Wishbone bus tasks
// Reference model of the setting outputs, compare process and compare tasks
module tb_u2_ctrl_core;

   localparam int BUS_TIMEOUT = 20;

   logic                wb_clk;
   logic                wb_rst;
   logic [15:0]         adr_i;
   wb_pkg::wb_data_t    dat_i;
   logic [3:0]          sel_i;
   logic                we_i;
   logic                stb_i;
   logic                cyc_i;
   wb_pkg::wb_data_t    dat_o;
   logic                ack_o;
   logic                err_o;
   logic                int_o;
   logic                run_rx_i;
   logic                run_tx_i;
   logic                clk_status_i;
   logic                serdes_link_up_i;
   logic                phy_int_n_i;
   logic                sim_mode_i;
   logic [3:0]          clock_divider_i;
   ctrl_pkg::led_word_t leds_o;
   logic                clock_ready_o;
   logic [1:0]          clk_en_o;
   logic [1:0]          clk_sel_o;
   logic                ser_enable_o;
   logic                ser_prbsen_o;
   logic                ser_loopen_o;
   logic                ser_rx_en_o;
   logic                adc_oe_a_o;
   logic                adc_on_a_o;
   logic                adc_oe_b_o;
   logic                adc_on_b_o;
   logic                phy_reset_n_o;

   // Expected contents of the setting registers
   logic [4:0]          sh_clock;
   logic [3:0]          sh_serdes;
   logic [3:0]          sh_adc;
   logic                sh_phy;
   ctrl_pkg::led_word_t sh_led;
   ctrl_pkg::led_word_t sh_src;

   logic [31:0]         rng_state;
   int                  mismatches = 0;
   int                  failures = 0;
   int                  chk_due = 0;

   u2_ctrl_core dut0 (.*);

   initial begin
      wb_clk = 1'b0;
      forever #4 wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////
   // Random numbers and address helpers
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand_word();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic [15:0] slave_addr(input logic [5:0] slave, input logic [7:0] idx);
      wb_pkg::wb_addr_u a;
      a.f.slave = slave;
      a.f.reg_index = idx;
      a.f.lane = 2'b00;
      return a.raw;
   endfunction

   // Expected {clock, serdes, adc, phy_reset_n, leds} from settings and hw inputs
   function automatic logic [21:0] ref_outputs(
      input logic [4:0] clock_r, input logic [3:0] serdes_r, input logic [3:0] adc_r,
      input logic phy_r, input ctrl_pkg::led_word_t sw, input ctrl_pkg::led_word_t src,
      input logic tx, input logic rx, input logic clk_ok, input logic link);
      ctrl_pkg::led_word_t hw;
      ctrl_pkg::led_word_t leds;
      hw = '0;
      hw[4] = tx;
      hw[3] = rx;
      hw[2] = clk_ok;
      hw[1] = link;
      for (int i = 0; i < 8; i++)
         leds[i] = src[i] ? hw[i] : sw[i];
      return {clock_r, serdes_r, adc_r, ~phy_r, leds};
   endfunction

   ////////////////////////////////////////
   // Compare tasks
   task automatic check_data(input string what, input wb_pkg::wb_data_t got,
                             input wb_pkg::wb_data_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s got %h expected %h", what, got, exp);
      end
   endtask

   task automatic check_leds(input string what, input ctrl_pkg::led_word_t got,
                             input ctrl_pkg::led_word_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s got %h expected %h", what, got, exp);
      end
   endtask

   task automatic check_irq(input string what, input ctrl_pkg::irq_vec_t got,
                            input ctrl_pkg::irq_vec_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s got %h expected %h", what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("mismatch %s got %h expected %h", what, got, exp);
      end
   endtask

   // Runs two falling edges after each request
   initial begin
      logic [21:0] exp_v;
      forever begin
         @(negedge wb_clk);
         if (chk_due > 0) begin
            chk_due = chk_due - 1;
            if (chk_due == 0) begin
               exp_v = ref_outputs(sh_clock, sh_serdes, sh_adc, sh_phy, sh_led, sh_src,
                                   run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i);
               check_data("clock_ready_o/clk_en_o/clk_sel_o",
                  wb_pkg::wb_data_t'({clock_ready_o, clk_en_o, clk_sel_o}),
                  wb_pkg::wb_data_t'(exp_v[21:17]));
               check_data("ser_enable_o/ser_prbsen_o/ser_loopen_o/ser_rx_en_o",
                  wb_pkg::wb_data_t'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}),
                  wb_pkg::wb_data_t'(exp_v[16:13]));
               check_data("adc_oe_a_o/adc_on_a_o/adc_oe_b_o/adc_on_b_o",
                  wb_pkg::wb_data_t'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}),
                  wb_pkg::wb_data_t'(exp_v[12:9]));
               check_bit("phy_reset_n_o", phy_reset_n_o, exp_v[8]);
               check_leds("leds_o", leds_o, exp_v[7:0]);
            end
         end
      end
   end

   ////////////////////////////////////////
   // Bus tasks
   task automatic bus_cycle(input logic [15:0] adr, input wb_pkg::wb_data_t wdata,
                            input logic we, output wb_pkg::wb_data_t rdata,
                            output logic got_ack, output logic got_err);
      int n;
      @(posedge wb_clk);
      adr_i <= adr;
      dat_i <= wdata;
      sel_i <= 4'hF;
      we_i  <= we;
      stb_i <= 1'b1;
      cyc_i <= 1'b1;
      got_ack = 1'b0;
      got_err = 1'b0;
      rdata = '0;
      n = 0;
      while (!got_ack && !got_err && n < BUS_TIMEOUT) begin
         @(negedge wb_clk);
         got_ack = ack_o;
         got_err = err_o;
         rdata = dat_o;
         n++;
      end
      if (!got_ack && !got_err) begin
         failures++;
         $display("bus cycle to address %h got neither ack nor err", adr);
      end
      @(posedge wb_clk);
      stb_i <= 1'b0;
      cyc_i <= 1'b0;
      we_i  <= 1'b0;
   endtask

   task automatic wb_write(input logic [15:0] adr, input wb_pkg::wb_data_t wdata);
      wb_pkg::wb_data_t rd;
      logic a;
      logic e;
      bus_cycle(adr, wdata, 1'b1, rd, a, e);
      if (e) begin
         failures++;
         $display("unexpected bus error on write to address %h", adr);
      end
   endtask

   task automatic wb_read(input logic [15:0] adr, output wb_pkg::wb_data_t rdata);
      logic a;
      logic e;
      bus_cycle(adr, '0, 1'b0, rdata, a, e);
      if (e) begin
         failures++;
         $display("unexpected bus error on read from address %h", adr);
      end
   endtask

   // Hand a check to the compare process and wait until it has run
   task automatic request_check();
      int n;
      chk_due = 2;
      n = 0;
      while (chk_due != 0 && n < 10) begin
         @(posedge wb_clk);
         n++;
      end
      if (chk_due != 0) begin
         failures++;
         $display("output compare did not run");
      end
   endtask

   task automatic set_write(input logic [7:0] sa, input wb_pkg::wb_data_t d);
      wb_write(slave_addr(wb_pkg::SLV_SETTINGS, sa), d);
      case (sa)
         ctrl_pkg::SR_CLOCK:   sh_clock  = d[4:0];
         ctrl_pkg::SR_SERDES:  sh_serdes = d[3:0];
         ctrl_pkg::SR_ADC:     sh_adc    = d[3:0];
         ctrl_pkg::SR_PHY:     sh_phy    = d[0];
         ctrl_pkg::SR_LED:     sh_led    = d[7:0];
         ctrl_pkg::SR_LED_SRC: sh_src    = d[7:0];
         default: ;
      endcase
      request_check();
   endtask

   task automatic drive_hw(input logic [31:0] r);
      @(posedge wb_clk);
      run_rx_i         <= r[0];
      run_tx_i         <= r[1];
      clk_status_i     <= r[2];
      serdes_link_up_i <= r[3];
      phy_int_n_i      <= r[4];
   endtask

   ////////////////////////////////////////
   // Stimulus
   initial begin
      wb_pkg::wb_data_t   rd;
      wb_pkg::wb_data_t   first;
      ctrl_pkg::irq_vec_t exp_irq;
      ctrl_pkg::irq_vec_t phy_bit;
      logic [31:0]        r;
      logic [7:0]         sa;
      logic               ack;
      logic               err;
      int                 n;
      rng_state = 32'h676d_c71e;
      wb_rst           <= 1'b1;
      adr_i            <= '0;
      dat_i            <= '0;
      sel_i            <= '0;
      we_i             <= 1'b0;
      stb_i            <= 1'b0;
      cyc_i            <= 1'b0;
      run_rx_i         <= 1'b0;
      run_tx_i         <= 1'b0;
      clk_status_i     <= 1'b0;
      serdes_link_up_i <= 1'b0;
      phy_int_n_i      <= 1'b0;
      sim_mode_i       <= 1'b0;
      clock_divider_i  <= '0;
      sh_clock  = '0;
      sh_serdes = '0;
      sh_adc    = '0;
      sh_phy    = 1'b0;
      sh_led    = '0;
      sh_src    = ctrl_pkg::LED_SRC_RESET;
      repeat (3) @(posedge wb_clk);
      wb_rst <= 1'b0;

      // State out of reset, all hardware LED sources high
      drive_hw(32'h0000_000F);
      wb_read(slave_addr(wb_pkg::SLV_READBACK, 8'd12), rd);
      check_data("dat_o word 12", rd, ctrl_pkg::COMPAT_NUM);
      request_check();
      @(negedge wb_clk);
      check_bit("int_o", int_o, 1'b0);

      // Clock, serdes, ADC and PHY settings
      for (int k = 0; k < 12; k++) begin
         r = rand_word();
         drive_hw(r);
         case (r[9:8])
            2'd0:    sa = ctrl_pkg::SR_CLOCK;
            2'd1:    sa = ctrl_pkg::SR_SERDES;
            2'd2:    sa = ctrl_pkg::SR_ADC;
            default: sa = ctrl_pkg::SR_PHY;
         endcase
         set_write(sa, rand_word());
      end

      // LED mux against random sources
      for (int k = 0; k < 12; k++) begin
         drive_hw(rand_word());
         set_write(ctrl_pkg::SR_LED, rand_word());
         set_write(ctrl_pkg::SR_LED_SRC, rand_word());
      end

      ////////////////////////////////////////
      // Status words
      r = rand_word();
      @(posedge wb_clk);
      sim_mode_i      <= r[31];
      clock_divider_i <= r[3:0];
      drive_hw(r >> 8);
      wb_read(slave_addr(wb_pkg::SLV_READBACK, 8'd9), rd);
      check_data("dat_o word 9", rd, {r[31], 27'd0, r[3:0]});
      exp_irq = '0;
      exp_irq[ctrl_pkg::IRQ_PHY] = r[12];
      exp_irq[ctrl_pkg::IRQ_SERDES] = r[11];
      exp_irq[ctrl_pkg::IRQ_CLK_STATUS] = r[10];
      wb_read(slave_addr(wb_pkg::SLV_READBACK, 8'd13), rd);
      check_irq("dat_o word 13", rd[15:0], exp_irq);
      check_data("dat_o word 13 upper half", wb_pkg::wb_data_t'(rd[31:16]), '0);
      wb_read(slave_addr(wb_pkg::SLV_READBACK, 8'd15), first);
      wb_read(slave_addr(wb_pkg::SLV_READBACK, 8'd15), rd);
      if (!(rd > first)) begin
         failures++;
         $display("cycle counter did not increase: %h then %h", first, rd);
      end

      ////////////////////////////////////////
      // PHY interrupt, edge triggered and active high
      phy_bit = '0;
      phy_bit[ctrl_pkg::IRQ_PHY] = 1'b1;
      @(posedge wb_clk);
      phy_int_n_i <= 1'b0;
      wb_write(slave_addr(wb_pkg::SLV_PIC, 8'd1), wb_pkg::wb_data_t'(phy_bit));
      wb_write(slave_addr(wb_pkg::SLV_PIC, 8'd0), wb_pkg::wb_data_t'(phy_bit));
      wb_write(slave_addr(wb_pkg::SLV_PIC, 8'd3), wb_pkg::wb_data_t'(phy_bit));
      wb_write(slave_addr(wb_pkg::SLV_PIC, 8'd2), wb_pkg::wb_data_t'(~phy_bit));
      @(negedge wb_clk);
      check_bit("int_o", int_o, 1'b0);
      @(posedge wb_clk);
      phy_int_n_i <= 1'b1;
      n = 0;
      while (int_o !== 1'b1 && n < BUS_TIMEOUT) begin
         @(negedge wb_clk);
         n++;
      end
      if (int_o !== 1'b1) begin
         failures++;
         $display("int_o did not rise after the PHY interrupt edge");
      end
      wb_read(slave_addr(wb_pkg::SLV_PIC, 8'd3), rd);
      check_irq("pic pending", rd[15:0] & phy_bit, phy_bit);
      wb_write(slave_addr(wb_pkg::SLV_PIC, 8'd3), wb_pkg::wb_data_t'(phy_bit));
      @(negedge wb_clk);
      check_bit("int_o", int_o, 1'b0);
      wb_read(slave_addr(wb_pkg::SLV_PIC, 8'd3), rd);
      check_irq("pic pending", rd[15:0] & phy_bit, '0);

      // Unmapped slave code
      bus_cycle(slave_addr(6'b000111, 8'd0), '0, 1'b0, rd, ack, err);
      // A slave that took the stb would ack one cycle later
      @(negedge wb_clk);
      ack = ack | ack_o;
      if (!err) begin
         failures++;
         $display("no err_o for a cycle to an unmapped slave code");
      end
      if (ack) begin
         failures++;
         $display("ack_o seen for a cycle to an unmapped slave code");
      end

      $display("mismatches: %0d, other errors: %0d", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

/* tb.f */
verilog/wb_pkg.sv
verilog/ctrl_pkg.sv
verilog/wb_if.sv
verilog/wb_slave_decode.sv
verilog/settings_bus_slave.sv
verilog/setting_bank.sv
verilog/readback_mux.sv
verilog/pic.sv
verilog/u2_ctrl_core.sv
verification/tb_u2_ctrl_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
   --top-module tb_u2_ctrl_core -Mdir obj_dir

./obj_dir/Vtb_u2_ctrl_core > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Finished with errors" sim.log; then
   exit 1
fi
